/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= rv_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILD_DIR)

/* tb.f */
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_writeback.sv
verilog/rv_core.sv
test/rv_core_tb.sv

/* test/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

  localparam logic [31:0] reset_pc = 32'h0000_0080;
  localparam logic [31:0] lfsr_seed = 32'ha67f_76cf;
  localparam int reset_cycles = 10;
  localparam int retire_target = 160;
  localparam int cycle_limit = 200;

  logic        clk;
  logic        rst;
  logic [31:0] pc_to_imem;
  logic [31:0] insn_from_imem;
  logic [31:0] trace_writeback_pc;
  logic [31:0] trace_writeback_insn;
  rv_pkg::cycle_status_e trace_writeback_cycle_status;
  logic        trace_writeback_we;
  logic [4:0]  trace_writeback_rd;
  logic [31:0] trace_writeback_data;

  logic [31:0] imem [0:63];
  logic [31:0] model_regs [0:31];
  logic [31:0] pc_hist [$];
  logic [31:0] insn_hist [$];
  logic [31:0] lfsr_state;
  logic [31:0] expected_pc;
  int          errors;
  int          retired;
  int          cycle;
  logic        timed_out;

  rv_core #(
    .reset_pc(reset_pc)
  ) dut0 (
    .clk                         (clk),
    .rst                         (rst),
    .pc_to_imem                  (pc_to_imem),
    .insn_from_imem              (insn_from_imem),
    .trace_writeback_pc          (trace_writeback_pc),
    .trace_writeback_insn        (trace_writeback_insn),
    .trace_writeback_cycle_status(trace_writeback_cycle_status),
    .trace_writeback_we          (trace_writeback_we),
    .trace_writeback_rd          (trace_writeback_rd),
    .trace_writeback_data        (trace_writeback_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // right-shifting galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] shift_right_arith(input logic [31:0] v, input logic [4:0] sh);
    logic [31:0] fill;
    fill = v[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    return (v >> sh) | fill;
  endfunction

  // registers limited to x0..x7 so hazards show up often
  task automatic build_program();
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f3;
    logic [31:0] bits;
    logic [31:0] alt;
    for (int i = 0; i < 64; i++) begin
      draw_bits(3, kind);
      draw_bits(3, rd);
      draw_bits(3, rs1);
      draw_bits(3, rs2);
      draw_bits(3, f3);
      draw_bits(1, alt);
      if (i % 16 == 11) begin
        // encodings outside the supported set
        rd = rd | 32'd1;
        draw_bits(12, bits);
        case (f3[1:0])
          2'd0: imem[i] = {bits[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
          2'd1: imem[i] = {7'b0000001, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
          2'd2: imem[i] = {7'b0100000, bits[4:0], rs1[4:0], 3'b001, rd[4:0], 7'b0010011};
          default: imem[i] = {bits[11:5], rs2[4:0], rs1[4:0], 3'b010, bits[4:0], 7'b0100011};
        endcase
      end else if (kind < 3) begin
        draw_bits(12, bits);
        if (f3[2:0] == 3'b001) begin
          bits[11:5] = 7'b0000000;
        end else if (f3[2:0] == 3'b101) begin
          bits[11:5] = alt[0] ? 7'b0100000 : 7'b0000000;
        end
        imem[i] = {bits[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
      end else if (kind < 7) begin
        bits = '0;
        if ((f3[2:0] == 3'b000 || f3[2:0] == 3'b101) && alt[0]) begin
          bits[6:0] = 7'b0100000;
        end
        imem[i] = {bits[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
      end else begin
        draw_bits(20, bits);
        imem[i] = {bits[19:0], rd[4:0], 7'b0110111};
      end
    end
  endtask

  // RV32I semantics on the model register state
  task automatic reference_step(input logic [31:0] insn, output logic exp_we,
                                output logic [4:0] exp_rd, output logic [31:0] exp_val);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [4:0]  sh;
    logic        legal;
    a = model_regs[insn[19:15]];
    b = model_regs[insn[24:20]];
    imm = {{20{insn[31]}}, insn[31:20]};
    sh = insn[24:20];
    exp_rd = insn[11:7];
    exp_val = '0;
    legal = 1'b1;
    case (insn[6:0])
      7'b0010011: begin
        case (insn[14:12])
          3'b000: exp_val = a + imm;
          3'b010: exp_val = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
          3'b011: exp_val = (a < imm) ? 32'd1 : 32'd0;
          3'b100: exp_val = a ^ imm;
          3'b110: exp_val = a | imm;
          3'b111: exp_val = a & imm;
          3'b001: begin
            if (insn[31:25] == 7'b0000000) exp_val = a << sh;
            else legal = 1'b0;
          end
          default: begin
            if (insn[31:25] == 7'b0000000) exp_val = a >> sh;
            else if (insn[31:25] == 7'b0100000) exp_val = shift_right_arith(a, sh);
            else legal = 1'b0;
          end
        endcase
      end
      7'b0110011: begin
        sh = b[4:0];
        case ({insn[31:25], insn[14:12]})
          10'b0000000_000: exp_val = a + b;
          10'b0100000_000: exp_val = a - b;
          10'b0000000_001: exp_val = a << sh;
          10'b0000000_010: exp_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          10'b0000000_011: exp_val = (a < b) ? 32'd1 : 32'd0;
          10'b0000000_100: exp_val = a ^ b;
          10'b0000000_101: exp_val = a >> sh;
          10'b0100000_101: exp_val = shift_right_arith(a, sh);
          10'b0000000_110: exp_val = a | b;
          10'b0000000_111: exp_val = a & b;
          default: legal = 1'b0;
        endcase
      end
      7'b0110111: exp_val = {insn[31:12], 12'h000};
      default: legal = 1'b0;
    endcase
    exp_we = legal && (exp_rd != 5'd0);
  endtask

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERR %s got %08h expected %08h at %0t", name, got, exp, $time);
    end
  endtask

  // reset and pipeline fill cycles
  task automatic expect_idle_trace();
    compare_word("trace_writeback_cycle_status", 32'(trace_writeback_cycle_status),
                 32'(rv_pkg::cycle_reset));
    compare_word("trace_writeback_we", 32'(trace_writeback_we), 32'd0);
    compare_word("trace_writeback_pc", trace_writeback_pc, 32'd0);
    compare_word("trace_writeback_insn", trace_writeback_insn, 32'd0);
  endtask

  task automatic retire_one();
    logic [31:0] exp_pc;
    logic [31:0] exp_insn;
    logic [31:0] exp_val;
    logic [4:0]  exp_rd;
    logic        exp_we;
    exp_pc = pc_hist.pop_front();
    exp_insn = insn_hist.pop_front();
    compare_word("trace_writeback_cycle_status", 32'(trace_writeback_cycle_status),
                 32'(rv_pkg::cycle_no_stall));
    compare_word("trace_writeback_pc", trace_writeback_pc, exp_pc);
    compare_word("trace_writeback_insn", trace_writeback_insn, exp_insn);
    reference_step(exp_insn, exp_we, exp_rd, exp_val);
    compare_word("trace_writeback_we", 32'(trace_writeback_we), 32'(exp_we));
    if (exp_we) begin
      compare_word("trace_writeback_rd", 32'(trace_writeback_rd), 32'(exp_rd));
      compare_word("trace_writeback_data", trace_writeback_data, exp_val);
      model_regs[exp_rd] = exp_val;
    end
    retired++;
  endtask

  // answer the current pc and remember it for the trace four cycles on
  task automatic feed_fetch();
    logic [31:0] word;
    compare_word("pc_to_imem", pc_to_imem, expected_pc);
    word = imem[pc_to_imem[7:2]];
    insn_from_imem = word;
    pc_hist.push_back(expected_pc);
    insn_hist.push_back(word);
    expected_pc = expected_pc + 32'd4;
  endtask

  initial begin
    errors = 0;
    retired = 0;
    cycle = 0;
    timed_out = 1'b0;
    rst = 1'b1;
    insn_from_imem = '0;
    expected_pc = reset_pc;
    lfsr_state = lfsr_seed;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    build_program();

    for (int i = 0; i < reset_cycles; i++) begin
      @(negedge clk);
      expect_idle_trace();
    end
    rst = 1'b0;
    feed_fetch();

    while (retired < retire_target && cycle < cycle_limit) begin
      @(negedge clk);
      cycle++;
      if (cycle < 4) begin
        expect_idle_trace();
      end else begin
        retire_one();
      end
      feed_fetch();
    end
    if (retired < retire_target) begin
      timed_out = 1'b1;
      $display("timeout: only %0d of %0d instructions retired within %0d cycles",
               retired, retire_target, cycle_limit);
    end

    $display("errors: %0d, instructions retired: %0d", errors, retired);
    if (timed_out || errors != 0) begin
      $display("Checks failed");
    end else begin
      $display("All checks passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = rv_pkg::reset_pc_default
) (
  input  logic                          clk,
  input  logic                          rst,
  output logic [rv_pkg::xlen-1:0]       pc_to_imem,
  input  logic [rv_pkg::xlen-1:0]       insn_from_imem,
  output logic [rv_pkg::xlen-1:0]       trace_writeback_pc,
  output logic [rv_pkg::xlen-1:0]       trace_writeback_insn,
  output rv_pkg::cycle_status_e         trace_writeback_cycle_status,
  output logic                          trace_writeback_we,
  output logic [rv_pkg::reg_addr_w-1:0] trace_writeback_rd,
  output logic [rv_pkg::xlen-1:0]       trace_writeback_data
);

  // fetch to decode
  logic [rv_pkg::xlen-1:0]       d_pc;
  logic [rv_pkg::xlen-1:0]       d_insn;
  rv_pkg::cycle_status_e         d_status;

  // register file read side
  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::reg_addr_w-1:0] rs2;
  logic [rv_pkg::xlen-1:0]       rs1_data;
  logic [rv_pkg::xlen-1:0]       rs2_data;

  // decode to execute
  logic [rv_pkg::xlen-1:0]       x_pc;
  logic [rv_pkg::xlen-1:0]       x_insn;
  logic [rv_pkg::reg_addr_w-1:0] x_rd;
  logic [rv_pkg::reg_addr_w-1:0] x_rs1;
  logic [rv_pkg::reg_addr_w-1:0] x_rs2;
  logic [rv_pkg::xlen-1:0]       x_op1;
  logic [rv_pkg::xlen-1:0]       x_op2;
  logic [rv_pkg::xlen-1:0]       x_imm;
  rv_pkg::alu_op_e               x_alu_op;
  logic                          x_writes_rd;
  rv_pkg::cycle_status_e         x_status;

  // memory stage
  logic [rv_pkg::xlen-1:0]       m_pc;
  logic [rv_pkg::xlen-1:0]       m_insn;
  logic [rv_pkg::reg_addr_w-1:0] m_rd;
  logic                          m_we;
  logic [rv_pkg::xlen-1:0]       m_result;
  rv_pkg::cycle_status_e         m_status;

  // writeback stage that also feeds the register file write port
  logic [rv_pkg::reg_addr_w-1:0] w_rd;
  logic                          w_we;
  logic [rv_pkg::xlen-1:0]       w_data;

  rv_fetch #(
    .reset_pc(reset_pc)
  ) fetch0 (
    .clk           (clk),
    .rst           (rst),
    .pc_to_imem    (pc_to_imem),
    .insn_from_imem(insn_from_imem),
    .d_pc          (d_pc),
    .d_insn        (d_insn),
    .d_status      (d_status)
  );

  rv_regfile regfile0 (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we      (w_we),
    .rd      (w_rd),
    .rd_data (w_data)
  );

  rv_decode decode0 (
    .clk        (clk),
    .rst        (rst),
    .d_pc       (d_pc),
    .d_insn     (d_insn),
    .d_status   (d_status),
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .x_pc       (x_pc),
    .x_insn     (x_insn),
    .x_rd       (x_rd),
    .x_rs1      (x_rs1),
    .x_rs2      (x_rs2),
    .x_op1      (x_op1),
    .x_op2      (x_op2),
    .x_imm      (x_imm),
    .x_alu_op   (x_alu_op),
    .x_writes_rd(x_writes_rd),
    .x_status   (x_status)
  );

  rv_execute execute0 (
    .clk        (clk),
    .rst        (rst),
    .x_pc       (x_pc),
    .x_insn     (x_insn),
    .x_rd       (x_rd),
    .x_rs1      (x_rs1),
    .x_rs2      (x_rs2),
    .x_op1      (x_op1),
    .x_op2      (x_op2),
    .x_imm      (x_imm),
    .x_alu_op   (x_alu_op),
    .x_writes_rd(x_writes_rd),
    .x_status   (x_status),
    .w_rd       (w_rd),
    .w_we       (w_we),
    .w_data     (w_data),
    .m_pc       (m_pc),
    .m_insn     (m_insn),
    .m_rd       (m_rd),
    .m_we       (m_we),
    .m_result   (m_result),
    .m_status   (m_status)
  );

  rv_writeback writeback0 (
    .clk                         (clk),
    .rst                         (rst),
    .m_pc                        (m_pc),
    .m_insn                      (m_insn),
    .m_rd                        (m_rd),
    .m_we                        (m_we),
    .m_result                    (m_result),
    .m_status                    (m_status),
    .w_rd                        (w_rd),
    .w_we                        (w_we),
    .w_data                      (w_data),
    .trace_writeback_pc          (trace_writeback_pc),
    .trace_writeback_insn        (trace_writeback_insn),
    .trace_writeback_cycle_status(trace_writeback_cycle_status),
    .trace_writeback_we          (trace_writeback_we),
    .trace_writeback_rd          (trace_writeback_rd),
    .trace_writeback_data        (trace_writeback_data)
  );

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       d_pc,
  input  logic [rv_pkg::xlen-1:0]       d_insn,
  input  rv_pkg::cycle_status_e         d_status,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::xlen-1:0]       rs1_data,
  input  logic [rv_pkg::xlen-1:0]       rs2_data,
  output logic [rv_pkg::xlen-1:0]       x_pc,
  output logic [rv_pkg::xlen-1:0]       x_insn,
  output logic [rv_pkg::reg_addr_w-1:0] x_rd,
  output logic [rv_pkg::reg_addr_w-1:0] x_rs1,
  output logic [rv_pkg::reg_addr_w-1:0] x_rs2,
  output logic [rv_pkg::xlen-1:0]       x_op1,
  output logic [rv_pkg::xlen-1:0]       x_op2,
  output logic [rv_pkg::xlen-1:0]       x_imm,
  output rv_pkg::alu_op_e               x_alu_op,
  output logic                          x_writes_rd,
  output rv_pkg::cycle_status_e         x_status
);

  rv_pkg::opcode_e         opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_u;
  rv_pkg::alu_op_e         alu_op;
  logic                    use_rs1;
  logic                    use_rs2;

  assign opcode = rv_pkg::opcode_e'(d_insn[6:0]);
  assign rd     = d_insn[11:7];
  assign funct3 = d_insn[14:12];
  assign rs1    = d_insn[19:15];
  assign rs2    = d_insn[24:20];
  assign funct7 = d_insn[31:25];

  assign imm_i = {{20{d_insn[31]}}, d_insn[31:20]};
  assign imm_u = {d_insn[31:12], 12'b0};

  always_comb begin
    alu_op  = rv_pkg::alu_nop;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      rv_pkg::op_reg_imm: begin
        use_rs1 = 1'b1;
        case (funct3)
          3'b000: alu_op = rv_pkg::alu_add;
          3'b010: alu_op = rv_pkg::alu_slt;
          3'b011: alu_op = rv_pkg::alu_sltu;
          3'b100: alu_op = rv_pkg::alu_xor;
          3'b110: alu_op = rv_pkg::alu_or;
          3'b111: alu_op = rv_pkg::alu_and;
          3'b001: if (funct7 == 7'b0000000) alu_op = rv_pkg::alu_sll;
          3'b101: begin
            if (funct7 == 7'b0000000) alu_op = rv_pkg::alu_srl;
            else if (funct7 == 7'b0100000) alu_op = rv_pkg::alu_sra;
          end
          default: alu_op = rv_pkg::alu_nop;
        endcase
      end
      rv_pkg::op_reg_reg: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = rv_pkg::alu_add;
          10'b0100000_000: alu_op = rv_pkg::alu_sub;
          10'b0000000_001: alu_op = rv_pkg::alu_sll;
          10'b0000000_010: alu_op = rv_pkg::alu_slt;
          10'b0000000_011: alu_op = rv_pkg::alu_sltu;
          10'b0000000_100: alu_op = rv_pkg::alu_xor;
          10'b0000000_101: alu_op = rv_pkg::alu_srl;
          10'b0100000_101: alu_op = rv_pkg::alu_sra;
          10'b0000000_110: alu_op = rv_pkg::alu_or;
          10'b0000000_111: alu_op = rv_pkg::alu_and;
          default:         alu_op = rv_pkg::alu_nop;
        endcase
      end
      rv_pkg::op_lui: alu_op = rv_pkg::alu_lui;
      default: alu_op = rv_pkg::alu_nop;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc        <= '0;
      x_insn      <= '0;
      x_rd        <= '0;
      x_rs1       <= '0;
      x_rs2       <= '0;
      x_alu_op    <= rv_pkg::alu_nop;
      x_writes_rd <= 1'b0;
      x_status    <= rv_pkg::cycle_reset;
    end else begin
      x_pc        <= d_pc;
      x_insn      <= d_insn;
      x_rd        <= rd;
      // unused source fields are zeroed so execute never forwards into them
      x_rs1       <= use_rs1 ? rs1 : '0;
      x_rs2       <= use_rs2 ? rs2 : '0;
      x_alu_op    <= alu_op;
      x_writes_rd <= (alu_op != rv_pkg::alu_nop) && (rd != '0);
      x_status    <= d_status;
    end
    x_op1 <= rs1_data;
    // immediate forms take their second operand from the instruction
    x_op2 <= (opcode == rv_pkg::op_reg_imm) ? imm_i : rs2_data;
    x_imm <= (opcode == rv_pkg::op_lui) ? imm_u : imm_i;
  end

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       x_pc,
  input  logic [rv_pkg::xlen-1:0]       x_insn,
  input  logic [rv_pkg::reg_addr_w-1:0] x_rd,
  input  logic [rv_pkg::reg_addr_w-1:0] x_rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] x_rs2,
  input  logic [rv_pkg::xlen-1:0]       x_op1,
  input  logic [rv_pkg::xlen-1:0]       x_op2,
  input  logic [rv_pkg::xlen-1:0]       x_imm,
  input  rv_pkg::alu_op_e               x_alu_op,
  input  logic                          x_writes_rd,
  input  rv_pkg::cycle_status_e         x_status,
  input  logic [rv_pkg::reg_addr_w-1:0] w_rd,
  input  logic                          w_we,
  input  logic [rv_pkg::xlen-1:0]       w_data,
  output logic [rv_pkg::xlen-1:0]       m_pc,
  output logic [rv_pkg::xlen-1:0]       m_insn,
  output logic [rv_pkg::reg_addr_w-1:0] m_rd,
  output logic                          m_we,
  output logic [rv_pkg::xlen-1:0]       m_result,
  output rv_pkg::cycle_status_e         m_status
);

  logic [rv_pkg::xlen-1:0] opa;
  logic [rv_pkg::xlen-1:0] opb;
  logic [rv_pkg::xlen-1:0] result;
  logic [4:0]              shamt;

  // youngest producer wins and x0 never forwards
  function automatic logic [rv_pkg::xlen-1:0] pick_operand(
    input logic [rv_pkg::reg_addr_w-1:0] src,
    input logic [rv_pkg::xlen-1:0]       decoded,
    input logic [rv_pkg::reg_addr_w-1:0] mem_rd,
    input logic                          mem_we,
    input logic [rv_pkg::xlen-1:0]       mem_val,
    input logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    input logic                          wb_we,
    input logic [rv_pkg::xlen-1:0]       wb_val
  );
    logic [rv_pkg::xlen-1:0] sel;
    sel = decoded;
    if (src != '0 && mem_we && mem_rd == src) begin
      sel = mem_val;
    end else if (src != '0 && wb_we && wb_rd == src) begin
      sel = wb_val;
    end
    return sel;
  endfunction

  assign opa = pick_operand(x_rs1, x_op1, m_rd, m_we, m_result, w_rd, w_we, w_data);
  assign opb = pick_operand(x_rs2, x_op2, m_rd, m_we, m_result, w_rd, w_we, w_data);

  assign shamt = opb[4:0];

  always_comb begin
    case (x_alu_op)
      rv_pkg::alu_add:  result = opa + opb;
      rv_pkg::alu_sub:  result = opa - opb;
      rv_pkg::alu_sll:  result = opa << shamt;
      rv_pkg::alu_slt:  result = {31'b0, $signed(opa) < $signed(opb)};
      rv_pkg::alu_sltu: result = {31'b0, opa < opb};
      rv_pkg::alu_xor:  result = opa ^ opb;
      rv_pkg::alu_srl:  result = opa >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(opa) >>> shamt);
      rv_pkg::alu_or:   result = opa | opb;
      rv_pkg::alu_and:  result = opa & opb;
      // upper immediate arrives already shifted
      rv_pkg::alu_lui:  result = x_imm;
      default:          result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= '0;
      m_rd     <= '0;
      m_we     <= 1'b0;
      m_status <= rv_pkg::cycle_reset;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_rd     <= x_rd;
      m_we     <= x_writes_rd;
      m_status <= x_status;
    end
    m_result <= result;
  end

endmodule

`default_nettype wire

/* verilog/rv_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_fetch #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = rv_pkg::reset_pc_default
) (
  input  logic                       clk,
  input  logic                       rst,
  output logic [rv_pkg::xlen-1:0]    pc_to_imem,
  input  logic [rv_pkg::xlen-1:0]    insn_from_imem,
  output logic [rv_pkg::xlen-1:0]    d_pc,
  output logic [rv_pkg::xlen-1:0]    d_insn,
  output rv_pkg::cycle_status_e      d_status
);

  logic [rv_pkg::xlen-1:0] pc;

  // no branches, so the pc only ever steps forward
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc + rv_pkg::insn_step;
    end
  end

  assign pc_to_imem = pc;

  // imem answers in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rv_pkg::cycle_reset;
    end else begin
      d_pc     <= pc;
      d_insn   <= insn_from_imem;
      d_status <= rv_pkg::cycle_no_stall;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // data path and program counter width
  localparam int xlen = 32;

  // register index width
  localparam int reg_addr_w = 5;

  // pc advance per fetched instruction
  localparam logic [xlen-1:0] insn_step = 4;

  // pc after reset unless the top level overrides it
  localparam logic [xlen-1:0] reset_pc_default = 32'h0000_0000;

  // major opcodes the core understands
  typedef enum logic [6:0] {
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_lui     = 7'b0110111
  } opcode_e;

  // operation selected in decode and carried to execute
  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_sll  = 5'd2,
    alu_slt  = 5'd3,
    alu_sltu = 5'd4,
    alu_xor  = 5'd5,
    alu_srl  = 5'd6,
    alu_sra  = 5'd7,
    alu_or   = 5'd8,
    alu_and  = 5'd9,
    alu_lui  = 5'd10,
    alu_nop  = 5'd11
  } alu_op_e;

  // what the writeback slot holds in a given cycle
  typedef enum logic [1:0] {
    cycle_invalid  = 2'd0,
    cycle_reset    = 2'd1,
    cycle_no_stall = 2'd2
  } cycle_status_e;

endpackage

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]       rd_data
);

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // a write in this cycle shows up on the read ports right away
  assign rs1_data = (rs1 == '0) ? '0 :
                    (we && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (we && rd == rs2) ? rd_data : regs[rs2];

endmodule

`default_nettype wire

/* verilog/rv_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_writeback (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       m_pc,
  input  logic [rv_pkg::xlen-1:0]       m_insn,
  input  logic [rv_pkg::reg_addr_w-1:0] m_rd,
  input  logic                          m_we,
  input  logic [rv_pkg::xlen-1:0]       m_result,
  input  rv_pkg::cycle_status_e         m_status,
  output logic [rv_pkg::reg_addr_w-1:0] w_rd,
  output logic                          w_we,
  output logic [rv_pkg::xlen-1:0]       w_data,
  output logic [rv_pkg::xlen-1:0]       trace_writeback_pc,
  output logic [rv_pkg::xlen-1:0]       trace_writeback_insn,
  output rv_pkg::cycle_status_e         trace_writeback_cycle_status,
  output logic                          trace_writeback_we,
  output logic [rv_pkg::reg_addr_w-1:0] trace_writeback_rd,
  output logic [rv_pkg::xlen-1:0]       trace_writeback_data
);

  // nothing happens in the memory stage, so its result is final here
  always_ff @(posedge clk) begin
    if (rst) begin
      trace_writeback_pc           <= '0;
      trace_writeback_insn         <= '0;
      trace_writeback_rd           <= '0;
      trace_writeback_we           <= 1'b0;
      trace_writeback_cycle_status <= rv_pkg::cycle_reset;
    end else begin
      trace_writeback_pc           <= m_pc;
      trace_writeback_insn         <= m_insn;
      trace_writeback_rd           <= m_rd;
      trace_writeback_we           <= m_we;
      trace_writeback_cycle_status <= m_status;
    end
    trace_writeback_data <= m_result;
  end

  // register file write port and execute bypass
  assign w_rd   = trace_writeback_rd;
  assign w_we   = trace_writeback_we;
  assign w_data = trace_writeback_data;

endmodule

`default_nettype wire
